// ==== list.f ====
+incdir+hw
+incdir+sim
hw/imu_spi_pkg.sv
hw/sensor_if.sv
hw/sensor_sync.sv
hw/packet_snapshot.sv
hw/spi_tx_shifter.sv
hw/imu_spi_slave.sv
sim/tb_imu_spi_slave.sv

// ==== sim/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------
// Compare tasks
// ----------------------------------------

task automatic compare_packet(input imu_spi_pkg::packet_u got,
                              input imu_spi_pkg::packet_u expected, input string what);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, expected);
    end
endtask

task automatic compare_byte(input logic [7:0] got, input logic [7:0] expected,
                            input string what);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, expected);
    end
endtask

task automatic compare_bit(input logic got, input logic expected, input string what);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, expected);
    end
endtask

// ----------------------------------------
// Reference packet
// ----------------------------------------

// Bits 0 to 3 are quat valid, gyro valid, initialized and error
function automatic logic [7:0] flags_byte(input logic qv, input logic gv,
                                          input logic init, input logic err);
    return {4'b0000, err, init, gv, qv};
endfunction

// Header, then every word high byte first, flags last
function automatic imu_spi_pkg::packet_u expected_packet(input logic [7:0] flags);
    imu_spi_pkg::packet_u word;
    word.bytes[0] = 8'hAA;
    for (int i = 0; i < 4; i++) begin
        word.bytes[1 + 2 * i] = exp_quat[i][15:8];
        word.bytes[2 + 2 * i] = exp_quat[i][7:0];
    end
    for (int i = 0; i < 3; i++) begin
        word.bytes[9 + 2 * i]  = exp_gyro[i][15:8];
        word.bytes[10 + 2 * i] = exp_gyro[i][7:0];
    end
    word.bytes[15] = flags;
    return word;
endfunction

// Called after both valids were pulsed, so the snapshot takes the pin values
task automatic capture_expected();
    for (int i = 0; i < 4; i++) exp_quat[i] = drv_quat[i];
    for (int i = 0; i < 3; i++) exp_gyro[i] = drv_gyro[i];
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------

task automatic test_full_packet();
    drive_sensor(1'b1, 1'b1, 1'b1, 1'b0);
    capture_expected();
    spi_read_bytes(16);
    compare_packet(received_packet(), expected_packet(8'h07), "full packet");
endtask

// Latches cleared at the end of the last read, so the data stays as it was
task automatic test_stale_hold();
    drive_sensor(1'b0, 1'b0, 1'b1, 1'b1);
    spi_read_bytes(16);
    compare_packet(received_packet(), expected_packet(flags_byte(1'b0, 1'b0, 1'b1, 1'b1)),
                   "stale hold");
endtask

task automatic test_frozen_snapshot();
    drive_sensor(1'b1, 1'b1, 1'b1, 1'b0);
    capture_expected();
    fork
        spi_read_bytes(16);
        begin
            // Well past the two clk it takes idle to fall
            repeat (8) @(negedge clk);
            drive_sensor(1'b1, 1'b1, 1'b1, 1'b0);
        end
    join
    compare_packet(received_packet(), expected_packet(8'h07), "frozen snapshot");
    // Pulses during the read were lost
    spi_read_bytes(16);
    compare_packet(received_packet(), expected_packet(flags_byte(1'b0, 1'b0, 1'b1, 1'b0)),
                   "after frozen");
endtask

task automatic test_overrun_and_idle();
    spi_read_bytes(20);
    compare_packet(received_packet(), expected_packet(flags_byte(1'b0, 1'b0, 1'b1, 1'b0)),
                   "overrun packet");
    for (int i = 16; i < 20; i++) compare_byte(rx_bytes[i], 8'h00, "byte past packet end");
    repeat (6) begin
        @(posedge clk);
        compare_bit(sdo, 1'b0, "sdo while deselected");
    end
    @(negedge clk);
    cs_n = 1'b0;
    @(posedge clk);
    compare_bit(sdo, 1'b1, "header MSB before first sck");
    @(negedge clk);
    cs_n = 1'b1;
    repeat (SETTLE_CYCLES) @(negedge clk);
endtask

task automatic test_abort_restart();
    spi_transfer(11);
    compare_byte(rx_bytes[0], 8'hAA, "header before abort");
    compare_byte(rx_bytes[1], {5'b00000, exp_quat[0][15:13]}, "three bits before abort");
    spi_read_bytes(16);
    compare_packet(received_packet(), expected_packet(flags_byte(1'b0, 1'b0, 1'b1, 1'b0)),
                   "after abort");
endtask

`endif

// ==== sim/tb_imu_spi_slave.sv ====
`timescale 1ns/1ps

module tb_imu_spi_slave;

    // ----------------------------------------
    // Bench timing
    // ----------------------------------------

    localparam int CLK_HALF_NS     = 10;
    localparam int RESET_CYCLES    = 4;
    localparam int SETTLE_CYCLES   = 10;
    localparam int SCK_LEAD_CYCLES = 4;
    localparam int SCK_HALF_CYCLES = 3;
    localparam int RX_BYTES        = 24;
    // Five tests of up to 20 bytes at 6 clk per bit, doubled, plus margin
    localparam int WATCHDOG_CYCLES = 5 * 20 * 8 * 6 * 2 + 2000;

    logic clk;
    logic cs_n;
    logic sck;
    logic sdo;
    logic quat_valid;
    logic gyro_valid;
    logic initialized;
    logic error;
    imu_spi_pkg::sample_t quat_w, quat_x, quat_y, quat_z;
    imu_spi_pkg::sample_t gyro_x, gyro_y, gyro_z;

    // Last samples put on the pins, and the samples the snapshot should hold
    imu_spi_pkg::sample_t drv_quat [0:3];
    imu_spi_pkg::sample_t drv_gyro [0:2];
    imu_spi_pkg::sample_t exp_quat [0:3];
    imu_spi_pkg::sample_t exp_gyro [0:2];

    logic [7:0]  rx_bytes [0:RX_BYTES-1];
    logic [15:0] lfsr_state;
    int          errors;
    int          checks;

    imu_spi_slave dut (
        .clk (clk), .cs_n (cs_n), .sck (sck), .sdo (sdo),
        .quat_valid (quat_valid), .gyro_valid (gyro_valid),
        .initialized (initialized), .error (error),
        .quat_w (quat_w), .quat_x (quat_x), .quat_y (quat_y), .quat_z (quat_z),
        .gyro_x (gyro_x), .gyro_y (gyro_y), .gyro_z (gyro_z)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF_NS) clk = ~clk;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Taps 16, 14, 13 and 11 give a maximal length sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // One LFSR step per sample bit
    task automatic take_random_sample(output imu_spi_pkg::sample_t value);
        value = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    // New random samples on every call, valids pulse for one clk when asked
    task automatic drive_sensor(input logic pulse_quat, input logic pulse_gyro,
                                input logic init_level, input logic error_level);
        for (int i = 0; i < 4; i++) take_random_sample(drv_quat[i]);
        for (int i = 0; i < 3; i++) take_random_sample(drv_gyro[i]);
        @(negedge clk);
        quat_w = drv_quat[0];
        quat_x = drv_quat[1];
        quat_y = drv_quat[2];
        quat_z = drv_quat[3];
        gyro_x = drv_gyro[0];
        gyro_y = drv_gyro[1];
        gyro_z = drv_gyro[2];
        initialized = init_level;
        error       = error_level;
        quat_valid  = pulse_quat;
        gyro_valid  = pulse_gyro;
        @(negedge clk);
        quat_valid = 1'b0;
        gyro_valid = 1'b0;
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    // Mode 0 master, sdo is read just as sck rises since it only moves on the fall
    task automatic spi_transfer(input int nbits);
        for (int i = 0; i < RX_BYTES; i++) rx_bytes[i] = 8'h00;
        @(negedge clk);
        cs_n = 1'b0;
        repeat (SCK_LEAD_CYCLES) @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            rx_bytes[i / 8] = {rx_bytes[i / 8][6:0], sdo};
            sck = 1'b1;
            repeat (SCK_HALF_CYCLES) @(negedge clk);
            sck = 1'b0;
            repeat (SCK_HALF_CYCLES) @(negedge clk);
        end
        cs_n = 1'b1;
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    task automatic spi_read_bytes(input int nbytes);
        spi_transfer(nbytes * 8);
    endtask

    // First 16 received bytes seen as a packet word
    function automatic imu_spi_pkg::packet_u received_packet();
        imu_spi_pkg::packet_u word;
        for (int i = 0; i < 16; i++) word.bytes[i] = rx_bytes[i];
        return word;
    endfunction

    `include "tb_checks.svh"

    // ----------------------------------------
    // Watchdog and test sequence
    // ----------------------------------------

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish within %0d clk cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        cs_n        = 1'b1;
        sck         = 1'b0;
        quat_valid  = 1'b0;
        gyro_valid  = 1'b0;
        initialized = 1'b0;
        error       = 1'b0;
        {quat_w, quat_x, quat_y, quat_z} = '0;
        {gyro_x, gyro_y, gyro_z} = '0;
        lfsr_state = 16'd91;
        errors     = 0;
        checks     = 0;
        // Chip select high holds the shifter in reset
        repeat (RESET_CYCLES) @(negedge clk);
        test_full_packet();
        test_stale_hold();
        test_frozen_snapshot();
        test_overrun_and_idle();
        test_abort_restart();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/imu_spi_slave.sv ====
`timescale 1ns/1ps
`include "imu_spi_settings.svh"

module imu_spi_slave (
    // System clock of the sensor side
    input  logic                            clk,
    // SPI side, the microcontroller is master
    input  logic                            cs_n,
    input  logic                            sck,
    output logic                            sdo,
    // Sensor side, pulses and levels from the IMU controller
    input  logic                            quat_valid,
    input  logic                            gyro_valid,
    input  logic                            initialized,
    input  logic                            error,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_w,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_x,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_y,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_z,
    input  logic signed [`IMU_SAMPLE_W-1:0] gyro_x,
    input  logic signed [`IMU_SAMPLE_W-1:0] gyro_y,
    input  logic signed [`IMU_SAMPLE_W-1:0] gyro_z
);

    // Capture to snapshot, all in clk
    sensor_if sensors ();

    // Snapshot to shifter, stable while cs_n is low
    imu_spi_pkg::packet_u packet;

    sensor_sync u_sensor_sync (
        .clk         (clk),
        .cs_n        (cs_n),
        .quat_valid  (quat_valid),
        .gyro_valid  (gyro_valid),
        .initialized (initialized),
        .error       (error),
        .quat_w      (quat_w),
        .quat_x      (quat_x),
        .quat_y      (quat_y),
        .quat_z      (quat_z),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z),
        .sensors     (sensors.source)
    );

    packet_snapshot u_packet_snapshot (
        .clk     (clk),
        .sensors (sensors.sink),
        .packet  (packet)
    );

    // The only logic clocked by sck
    spi_tx_shifter u_spi_tx_shifter (
        .sck    (sck),
        .cs_n   (cs_n),
        .packet (packet),
        .sdo    (sdo)
    );

endmodule

// ==== hw/spi_tx_shifter.sv ====
`timescale 1ns/1ps
`include "imu_spi_settings.svh"

module spi_tx_shifter (
    input  logic                 sck,
    input  logic                 cs_n,
    input  imu_spi_pkg::packet_u packet,
    output logic                 sdo
);

    // SPI mode 0: the master samples on rising sck, so new bits are put
    // out on falling sck

    localparam int BYTE_W = $clog2(`IMU_PACKET_BYTES);

    // Byte count saturates here, one past the last packet byte
    localparam logic [BYTE_W:0] PKT_BYTES = (BYTE_W + 1)'(`IMU_PACKET_BYTES);

    logic              seen_rise;
    logic [2:0]        bit_cnt;
    logic [BYTE_W:0]   byte_cnt;
    logic [BYTE_W:0]   next_byte;
    logic [7:0]        shift_reg;

    // ----------------------------------------
    // First rising edge
    // ----------------------------------------

    // The header MSB is already on sdo when cs_n falls, so the first
    // falling edge must not shift until the master has sampled it once
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            seen_rise <= 1'b0;
        end else begin
            seen_rise <= 1'b1;
        end
    end

    // ----------------------------------------
    // Counters and shift register
    // ----------------------------------------

    assign next_byte = byte_cnt + 1'b1;

    // cs_n high holds everything at the start of a packet, which also
    // makes a raised chip select abort and restart cleanly
    always_ff @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            shift_reg <= `IMU_HEADER_BYTE;
        end else if (seen_rise) begin
            if (bit_cnt == 3'd7) begin
                // Byte boundary
                bit_cnt <= '0;
                if (byte_cnt != PKT_BYTES) begin
                    byte_cnt <= next_byte;
                end
                // Past the end of the packet the master only gets zeros
                if (next_byte < PKT_BYTES) begin
                    shift_reg <= packet.bytes[next_byte[BYTE_W-1:0]];
                end else begin
                    shift_reg <= 8'h00;
                end
            end else begin
                // MSB first
                bit_cnt   <= bit_cnt + 3'd1;
                shift_reg <= {shift_reg[6:0], 1'b0};
            end
        end
    end

    // Line is held low when not selected
    assign sdo = cs_n ? 1'b0 : shift_reg[7];

endmodule

// ==== hw/packet_snapshot.sv ====
`timescale 1ns/1ps
`include "imu_spi_settings.svh"

module packet_snapshot (
    input  logic                clk,
    sensor_if.sink              sensors,
    output imu_spi_pkg::packet_u packet
);

    // Snapshot copies of the samples
    imu_spi_pkg::sample_t quat_w_snap;
    imu_spi_pkg::sample_t quat_x_snap;
    imu_spi_pkg::sample_t quat_y_snap;
    imu_spi_pkg::sample_t quat_z_snap;
    imu_spi_pkg::sample_t gyro_x_snap;
    imu_spi_pkg::sample_t gyro_y_snap;
    imu_spi_pkg::sample_t gyro_z_snap;

    // Snapshot copies of the four flags
    logic quat_valid_snap;
    logic gyro_valid_snap;
    logic initialized_snap;
    logic error_snap;

    logic [7:0] flags_byte;

    // ----------------------------------------
    // Snapshot registers
    // ----------------------------------------

    // While idle the snapshot follows the sensor, once chip select is
    // active it freezes so the whole packet comes from one moment
    always_ff @(posedge clk) begin
        if (sensors.idle) begin
            // A data group only moves when fresh data was flagged for it,
            // otherwise the last good values stay in place
            if (sensors.quat_valid) begin
                quat_w_snap <= sensors.quat_w;
                quat_x_snap <= sensors.quat_x;
                quat_y_snap <= sensors.quat_y;
                quat_z_snap <= sensors.quat_z;
            end
            if (sensors.gyro_valid) begin
                gyro_x_snap <= sensors.gyro_x;
                gyro_y_snap <= sensors.gyro_y;
                gyro_z_snap <= sensors.gyro_z;
            end
            // Flags always reflect the present state
            quat_valid_snap  <= sensors.quat_valid;
            gyro_valid_snap  <= sensors.gyro_valid;
            initialized_snap <= sensors.initialized;
            error_snap       <= sensors.error;
        end
    end

    // ----------------------------------------
    // Packet assembly
    // ----------------------------------------

    always_comb begin
        // Unused upper bits stay zero
        flags_byte = '0;
        flags_byte[`IMU_FLAG_QUAT_VALID]  = quat_valid_snap;
        flags_byte[`IMU_FLAG_GYRO_VALID]  = gyro_valid_snap;
        flags_byte[`IMU_FLAG_INITIALIZED] = initialized_snap;
        flags_byte[`IMU_FLAG_ERROR]       = error_snap;
    end

    // Field order in the struct gives the wire order
    always_comb begin
        packet.fields.header = `IMU_HEADER_BYTE;
        packet.fields.quat_w = quat_w_snap;
        packet.fields.quat_x = quat_x_snap;
        packet.fields.quat_y = quat_y_snap;
        packet.fields.quat_z = quat_z_snap;
        packet.fields.gyro_x = gyro_x_snap;
        packet.fields.gyro_y = gyro_y_snap;
        packet.fields.gyro_z = gyro_z_snap;
        packet.fields.flags  = flags_byte;
    end

endmodule

// ==== hw/sensor_sync.sv ====
`timescale 1ns/1ps
`include "imu_spi_settings.svh"

module sensor_sync (
    input  logic                            clk,
    input  logic                            cs_n,
    input  logic                            quat_valid,
    input  logic                            gyro_valid,
    input  logic                            initialized,
    input  logic                            error,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_w,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_x,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_y,
    input  logic signed [`IMU_SAMPLE_W-1:0] quat_z,
    input  logic signed [`IMU_SAMPLE_W-1:0] gyro_x,
    input  logic signed [`IMU_SAMPLE_W-1:0] gyro_y,
    input  logic signed [`IMU_SAMPLE_W-1:0] gyro_z,
    sensor_if.source                        sensors
);

    // Lanes of the shared synchronizer chain
    localparam int SYNC_W    = 5;
    localparam int SYNC_IDLE = 0;
    localparam int SYNC_QV   = 1;
    localparam int SYNC_GV   = 2;
    localparam int SYNC_INIT = 3;
    localparam int SYNC_ERR  = 4;

    localparam int LAST = `IMU_SYNC_STAGES - 1;

    logic                                    initialized_q;
    logic                                    error_q;
    logic [SYNC_W-1:0]                       sync_in;
    logic [`IMU_SYNC_STAGES-1:0][SYNC_W-1:0] sync_q;
    logic [SYNC_W-1:0]                       sync_out;
    logic                                    cs_rise;
    logic                                    quat_latch;
    logic                                    gyro_latch;

    // ----------------------------------------
    // Input capture
    // ----------------------------------------

    // Samples go straight onto the interface one clk after the top inputs
    // Status levels get one register here before entering the chain
    always_ff @(posedge clk) begin
        sensors.quat_w <= quat_w;
        sensors.quat_x <= quat_x;
        sensors.quat_y <= quat_y;
        sensors.quat_z <= quat_z;
        sensors.gyro_x <= gyro_x;
        sensors.gyro_y <= gyro_y;
        sensors.gyro_z <= gyro_z;
        initialized_q  <= initialized;
        error_q        <= error;
    end

    // ----------------------------------------
    // Synchronizer chain
    // ----------------------------------------

    // The valid pulses and cs_n enter the chain directly, its first stage
    // is their capture register
    assign sync_in = {error_q, initialized_q, gyro_valid, quat_valid, cs_n};

    always_ff @(posedge clk) begin
        sync_q[0] <= sync_in;
        for (int i = 1; i < `IMU_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign sync_out = sync_q[LAST];

    // Chip select is one stage away from rising at the chain output
    // Clearing on this look-ahead means the latches read clear in the
    // very first idle cycle, before the snapshot can reload from them
    assign cs_rise = sync_q[LAST-1][SYNC_IDLE] & ~sync_out[SYNC_IDLE];

    // ----------------------------------------
    // Valid latches
    // ----------------------------------------

    // A transaction end wins over a pulse arriving on the same edge
    always_ff @(posedge clk) begin
        if (cs_rise) begin
            quat_latch <= 1'b0;
            gyro_latch <= 1'b0;
        end else if (sync_out[SYNC_IDLE]) begin
            // Only set here, never cleared, so a single pulse is enough
            if (sync_out[SYNC_QV]) begin
                quat_latch <= 1'b1;
            end
            if (sync_out[SYNC_GV]) begin
                gyro_latch <= 1'b1;
            end
        end
        // While a transaction runs the latches hold and new pulses are lost
    end

    assign sensors.quat_valid  = quat_latch;
    assign sensors.gyro_valid  = gyro_latch;
    assign sensors.initialized = sync_out[SYNC_INIT];
    assign sensors.error       = sync_out[SYNC_ERR];
    assign sensors.idle        = sync_out[SYNC_IDLE];

endmodule

// ==== hw/sensor_if.sv ====
`timescale 1ns/1ps
`include "imu_spi_settings.svh"

// Carries the clk-domain view of the sensor from capture to snapshot
// Everything here is a plain level, there is no handshake
interface sensor_if;

    // Samples registered once in the clk domain
    logic signed [`IMU_SAMPLE_W-1:0] quat_w;
    logic signed [`IMU_SAMPLE_W-1:0] quat_x;
    logic signed [`IMU_SAMPLE_W-1:0] quat_y;
    logic signed [`IMU_SAMPLE_W-1:0] quat_z;
    logic signed [`IMU_SAMPLE_W-1:0] gyro_x;
    logic signed [`IMU_SAMPLE_W-1:0] gyro_y;
    logic signed [`IMU_SAMPLE_W-1:0] gyro_z;

    // Latched copies of the one-cycle valid pulses
    logic quat_valid;
    logic gyro_valid;

    // Synchronized status levels
    logic initialized;
    logic error;

    // Chip select brought into clk, high while no transaction runs
    logic idle;

    modport source (
        output quat_w, quat_x, quat_y, quat_z,
        output gyro_x, gyro_y, gyro_z,
        output quat_valid, gyro_valid, initialized, error, idle
    );

    modport sink (
        input quat_w, quat_x, quat_y, quat_z,
        input gyro_x, gyro_y, gyro_z,
        input quat_valid, gyro_valid, initialized, error, idle
    );

endinterface

// ==== hw/imu_spi_pkg.sv ====
`include "imu_spi_settings.svh"

package imu_spi_pkg;

    // One signed sensor sample as delivered by the IMU controller
    typedef logic signed [`IMU_SAMPLE_W-1:0] sample_t;

    // ----------------------------------------
    // Packet seen field by field
    // ----------------------------------------

    // Members are listed in transmit order, so the header lands in the top
    // byte of the 128-bit word and the flags byte in the bottom one
    // Each sample is stored MSB byte first, which is also the wire order
    typedef struct packed {
        logic [7:0] header;
        sample_t    quat_w;
        sample_t    quat_x;
        sample_t    quat_y;
        sample_t    quat_z;
        sample_t    gyro_x;
        sample_t    gyro_y;
        sample_t    gyro_z;
        logic [7:0] flags;
    } packet_fields_t;

    // ----------------------------------------
    // Same word seen two ways
    // ----------------------------------------

    // The assembler writes through the fields view
    // The shifter reads through the bytes view, where index 0 is the most
    // significant byte and therefore the first byte on the wire
    typedef union packed {
        packet_fields_t                         fields;
        logic [0:`IMU_PACKET_BYTES-1][7:0]      bytes;
    } packet_u;

endpackage

// ==== hw/imu_spi_settings.svh ====
`ifndef IMU_SPI_SETTINGS_SVH
`define IMU_SPI_SETTINGS_SVH

// ----------------------------------------
// Data widths and packet layout
// ----------------------------------------

// Width of one signed quaternion or gyro sample
`define IMU_SAMPLE_W 16

// Bytes per packet: header, seven words, flags
`define IMU_PACKET_BYTES 16

// First byte the microcontroller looks for
`define IMU_HEADER_BYTE 8'hAA

// Flip-flops in each clk-domain synchronizer chain
`define IMU_SYNC_STAGES 2

// ----------------------------------------
// Bit positions inside the flags byte
// ----------------------------------------

// The upper four bits of the flags byte always read as zero
`define IMU_FLAG_QUAT_VALID 0
`define IMU_FLAG_GYRO_VALID 1
`define IMU_FLAG_INITIALIZED 2
`define IMU_FLAG_ERROR 3

`endif
